//--- rv32i_types.sv
package rv32i_types;

    localparam int xlen = 32;
    localparam int reg_addr_width = 5;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    // funct3 order, sub/sra via alu_sub_sra
    typedef enum logic [2:0] {
        alu_add  = 3'b000,
        alu_sll  = 3'b001,
        alu_slt  = 3'b010,
        alu_sltu = 3'b011,
        alu_xor  = 3'b100,
        alu_sr   = 3'b101,
        alu_or   = 3'b110,
        alu_and  = 3'b111
    } alu_ops;

    typedef enum logic {
        cmpmux_rs2   = 1'b0,
        cmpmux_i_imm = 1'b1
    } cmpmux_sel_t;

    typedef enum logic {
        alumux1_rs1 = 1'b0,
        alumux1_pc  = 1'b1
    } alumux1_sel_t;

    typedef enum logic [2:0] {
        alumux2_i_imm = 3'd0,
        alumux2_u_imm = 3'd1,
        alumux2_b_imm = 3'd2,
        alumux2_s_imm = 3'd3,
        alumux2_j_imm = 3'd4,
        alumux2_rs2   = 3'd5
    } alumux2_sel_t;

    typedef enum logic [2:0] {
        regfilemux_alu_out  = 3'd0,
        regfilemux_br_en    = 3'd1,
        regfilemux_u_imm    = 3'd2,
        regfilemux_load     = 3'd3, // width/sign from funct3
        regfilemux_pc_plus4 = 3'd4
    } regfilemux_sel_t;

    typedef struct packed {
        rv32i_opcode     opcode;
        alu_ops          aluop;
        logic            alu_sub_sra;
        alumux1_sel_t    alumux1_sel;
        alumux2_sel_t    alumux2_sel;
        regfilemux_sel_t regfilemux_sel;
        logic            load_regfile;
        logic            mem_read;
        logic            mem_write;
        branch_funct3_t  cmpop;
        cmpmux_sel_t     cmpmux_sel;
        logic [2:0]      funct3;
        logic            illegal;
    } rv32i_control_word;

    typedef struct packed {
        logic [xlen-1:0] instr;
        logic [xlen-1:0] pc;
    } if_id_t;

    typedef struct packed {
        rv32i_control_word         ctrl;
        logic [xlen-1:0]           instr;
        logic [xlen-1:0]           pc;
        logic [xlen-1:0]           rs1_out;
        logic [xlen-1:0]           rs2_out;
        logic [xlen-1:0]           i_imm;
        logic [xlen-1:0]           s_imm;
        logic [xlen-1:0]           b_imm;
        logic [xlen-1:0]           u_imm;
        logic [xlen-1:0]           j_imm;
        logic [reg_addr_width-1:0] rd;
        logic                      br_en;
    } id_ex_t;

endpackage : rv32i_types

//--- control_rom.sv
module control_rom (
    input  rv32i_types::rv32i_opcode       opcode_i,
    input  logic [2:0]                     funct3_i,
    input  logic [6:0]                     funct7_i,
    output rv32i_types::rv32i_control_word ctrl_o
);
    import rv32i_types::*;

    always_comb begin
        ctrl_o.opcode         = opcode_i;
        ctrl_o.aluop          = alu_ops'(funct3_i);
        ctrl_o.alu_sub_sra    = 1'b0;
        ctrl_o.alumux1_sel    = alumux1_rs1;
        ctrl_o.alumux2_sel    = alumux2_i_imm;
        ctrl_o.regfilemux_sel = regfilemux_alu_out;
        ctrl_o.load_regfile   = 1'b0;
        ctrl_o.mem_read       = 1'b0;
        ctrl_o.mem_write      = 1'b0;
        ctrl_o.cmpop          = beq;
        ctrl_o.cmpmux_sel     = cmpmux_rs2;
        ctrl_o.funct3         = funct3_i;
        ctrl_o.illegal        = 1'b0;

        case (opcode_i)
            op_lui: begin
                ctrl_o.load_regfile   = 1'b1;
                ctrl_o.regfilemux_sel = regfilemux_u_imm;
            end
            op_auipc: begin
                ctrl_o.load_regfile = 1'b1;
                ctrl_o.aluop        = alu_add;
                ctrl_o.alumux1_sel  = alumux1_pc;
                ctrl_o.alumux2_sel  = alumux2_u_imm;
            end
            op_jal: begin
                ctrl_o.load_regfile   = 1'b1;
                ctrl_o.regfilemux_sel = regfilemux_pc_plus4;
                ctrl_o.aluop          = alu_add;
                ctrl_o.alumux1_sel    = alumux1_pc;
                ctrl_o.alumux2_sel    = alumux2_j_imm;
            end
            op_jalr: begin
                ctrl_o.load_regfile   = 1'b1;
                ctrl_o.regfilemux_sel = regfilemux_pc_plus4;
                ctrl_o.aluop          = alu_add; // target = rs1 + i_imm
            end
            op_br: begin
                ctrl_o.aluop       = alu_add;
                ctrl_o.alumux1_sel = alumux1_pc;
                ctrl_o.alumux2_sel = alumux2_b_imm;
                ctrl_o.cmpop       = branch_funct3_t'(funct3_i);
                ctrl_o.cmpmux_sel  = cmpmux_rs2;
            end
            op_load: begin
                ctrl_o.load_regfile   = 1'b1;
                ctrl_o.mem_read       = 1'b1;
                ctrl_o.aluop          = alu_add;
                ctrl_o.regfilemux_sel = regfilemux_load;
            end
            op_store: begin
                ctrl_o.mem_write   = 1'b1;
                ctrl_o.aluop       = alu_add;
                ctrl_o.alumux2_sel = alumux2_s_imm;
            end
            op_imm, op_reg: begin
                ctrl_o.load_regfile = 1'b1;
                if (opcode_i == op_reg) begin
                    ctrl_o.alumux2_sel = alumux2_rs2;
                end
                if (funct3_i == 3'b010 || funct3_i == 3'b011) begin
                    ctrl_o.regfilemux_sel = regfilemux_br_en; // slt via comparator
                    ctrl_o.cmpop          = funct3_i[0] ? bltu : blt;
                    ctrl_o.cmpmux_sel     = (opcode_i == op_imm) ? cmpmux_i_imm : cmpmux_rs2;
                end
                if (funct3_i == 3'b101 || (opcode_i == op_reg && funct3_i == 3'b000)) begin
                    ctrl_o.alu_sub_sra = funct7_i[5]; // sra or sub
                end
            end
            default: ctrl_o.illegal = 1'b1;
        endcase
    end

    always_comb begin
        assert (!(ctrl_o.mem_read && ctrl_o.mem_write))
            else $error("control_rom: mem_read and mem_write both set");
    end

endmodule : control_rom

//--- regfile.sv
module regfile (
    input  logic                                  clk,
    input  logic                                  rst_i,
    input  logic                                  load_i,
    input  logic [rv32i_types::reg_addr_width-1:0] dest_i,
    input  logic [rv32i_types::xlen-1:0]           in_i,
    input  logic [rv32i_types::reg_addr_width-1:0] src_a_i,
    input  logic [rv32i_types::reg_addr_width-1:0] src_b_i,
    output logic [rv32i_types::xlen-1:0]           reg_a_o,
    output logic [rv32i_types::xlen-1:0]           reg_b_o
);
    import rv32i_types::*;

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (load_i && dest_i != '0) begin
            regs[dest_i] <= in_i; // x0 keeps its reset value
        end
    end

    // same-cycle writeback bypasses the array, never for x0
    assign reg_a_o = (load_i && dest_i != '0 && dest_i == src_a_i) ? in_i : regs[src_a_i];
    assign reg_b_o = (load_i && dest_i != '0 && dest_i == src_b_i) ? in_i : regs[src_b_i];

    a_x0_zero: assert property (@(posedge clk) disable iff (rst_i)
        (src_a_i != '0 || reg_a_o == '0) && (src_b_i != '0 || reg_b_o == '0))
        else $error("regfile: x0 read returned nonzero");

endmodule : regfile

//--- pipe_reg.sv
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_i,
    input  logic     stall_i,
    input  logic     flush_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
            data_o  <= '0;
        end else if (flush_i) begin
            valid_o <= 1'b0; // flush beats stall
        end else if (!stall_i) begin
            valid_o <= valid_i;
            data_o  <= data_i;
        end
    end

    // a flushed stage shows no item on the next cycle
    a_flush_clears: assert property (@(posedge clk) flush_i |=> !valid_o)
        else $error("pipe_reg: valid_o high after flush");

endmodule : pipe_reg

//--- id_stage.sv
module id_stage (
    input  logic                                   clk,
    input  logic                                   rst_i,
    input  logic                                   load_regfile_i, // from wb
    input  logic [rv32i_types::reg_addr_width-1:0] rd_wr_i,
    input  logic [rv32i_types::xlen-1:0]           wr_data_i,
    input  logic                                   valid_i,
    input  rv32i_types::if_id_t                    if_id_i,
    output rv32i_types::id_ex_t                    id_ex_o
);
    import rv32i_types::*;

    logic [xlen-1:0]           instr;
    rv32i_opcode               opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [reg_addr_width-1:0] rs1;
    logic [reg_addr_width-1:0] rs2;
    logic [reg_addr_width-1:0] rd;
    logic [xlen-1:0]           i_imm;
    logic [xlen-1:0]           s_imm;
    logic [xlen-1:0]           b_imm;
    logic [xlen-1:0]           u_imm;
    logic [xlen-1:0]           j_imm;
    logic [xlen-1:0]           rs1_out;
    logic [xlen-1:0]           rs2_out;
    logic [xlen-1:0]           cmp_opnd;
    logic                      br_en;
    rv32i_control_word         ctrl;

    always_comb begin
        instr  = if_id_i.instr;
        opcode = rv32i_opcode'(instr[6:0]);
        funct3 = instr[14:12];
        funct7 = instr[31:25];
        rs1    = instr[19:15];
        rs2    = instr[24:20];
        rd     = instr[11:7];

        i_imm = {{21{instr[31]}}, instr[30:20]};
        s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
        b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        u_imm = {instr[31:12], 12'h000};
        j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    end

    control_rom u_control_rom (
        .opcode_i (opcode),
        .funct3_i (funct3),
        .funct7_i (funct7),
        .ctrl_o   (ctrl)
    );

    regfile u_regfile (
        .clk     (clk),
        .rst_i   (rst_i),
        .load_i  (load_regfile_i),
        .dest_i  (rd_wr_i),
        .in_i    (wr_data_i),
        .src_a_i (rs1),
        .src_b_i (rs2),
        .reg_a_o (rs1_out),
        .reg_b_o (rs2_out)
    );

    assign cmp_opnd = (ctrl.cmpmux_sel == cmpmux_i_imm) ? i_imm : rs2_out;

    always_comb begin
        case (ctrl.cmpop)
            beq:     br_en = (rs1_out == cmp_opnd);
            bne:     br_en = (rs1_out != cmp_opnd);
            blt:     br_en = ($signed(rs1_out) < $signed(cmp_opnd));
            bge:     br_en = ($signed(rs1_out) >= $signed(cmp_opnd));
            bltu:    br_en = (rs1_out < cmp_opnd);
            bgeu:    br_en = (rs1_out >= cmp_opnd);
            default: br_en = 1'b0; // funct3 010/011 on a branch
        endcase
    end

    always_comb begin
        id_ex_o = '{ctrl: ctrl, instr: instr, pc: if_id_i.pc,
                    rs1_out: rs1_out, rs2_out: rs2_out,
                    i_imm: i_imm, s_imm: s_imm, b_imm: b_imm,
                    u_imm: u_imm, j_imm: j_imm, rd: rd, br_en: br_en};
    end

    // fetch only hands over 32-bit encodings
    a_instr_32bit: assert property (@(posedge clk) disable iff (rst_i)
        valid_i |-> (if_id_i.instr[1:0] == 2'b11))
        else $error("id_stage: valid instruction with low bits %b", if_id_i.instr[1:0]);

endmodule : id_stage

//--- decode_slice.sv
module decode_slice (
    input  logic                                   clk,
    input  logic                                   rst_i,
    input  logic                                   stall_i,
    input  logic                                   flush_i,
    input  logic                                   if_valid_i,
    input  logic [rv32i_types::xlen-1:0]           if_instr_i,
    input  logic [rv32i_types::xlen-1:0]           if_pc_i,
    input  logic                                   wb_load_i,
    input  logic [rv32i_types::reg_addr_width-1:0] wb_rd_i,
    input  logic [rv32i_types::xlen-1:0]           wb_data_i,
    output logic                                   ex_valid_o,
    output rv32i_types::id_ex_t                    ex_payload_o
);
    import rv32i_types::*;

    if_id_t if_id_d;
    if_id_t if_id_q;
    logic   if_id_valid;
    id_ex_t id_ex_d;

    assign if_id_d = '{instr: if_instr_i, pc: if_pc_i};

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk     (clk),
        .rst_i   (rst_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .valid_i (if_valid_i),
        .data_i  (if_id_d),
        .valid_o (if_id_valid),
        .data_o  (if_id_q)
    );

    id_stage u_id_stage (
        .clk            (clk),
        .rst_i          (rst_i),
        .load_regfile_i (wb_load_i),
        .rd_wr_i        (wb_rd_i),
        .wr_data_i      (wb_data_i),
        .valid_i        (if_id_valid),
        .if_id_i        (if_id_q),
        .id_ex_o        (id_ex_d)
    );

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk     (clk),
        .rst_i   (rst_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .valid_i (if_id_valid), // valid follows the item from IF/ID
        .data_i  (id_ex_d),
        .valid_o (ex_valid_o),
        .data_o  (ex_payload_o)
    );

endmodule : decode_slice

//--- tb_decode_slice.sv
module tb_decode_slice;
    import rv32i_types::*;

    localparam int num_cycles     = 3000;
    localparam int reset_cycles   = 8;
    localparam int timeout_cycles = num_cycles + reset_cycles + 100;

    logic                      clk;
    logic                      rst_i;
    logic                      stall_i;
    logic                      flush_i;
    logic                      if_valid_i;
    logic [xlen-1:0]           if_instr_i;
    logic [xlen-1:0]           if_pc_i;
    logic                      wb_load_i;
    logic [reg_addr_width-1:0] wb_rd_i;
    logic [xlen-1:0]           wb_data_i;
    logic                      ex_valid_o;
    id_ex_t                    ex_payload_o;

    logic [xlen-1:0] regs_m [32]; // architectural register model
    logic            ifid_v_m;
    if_id_t          ifid_m;
    logic            ex_v_m;
    id_ex_t          ex_m;
    int              cycle_cnt = 0;

    decode_slice u_decode_slice (
        .clk          (clk),
        .rst_i        (rst_i),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .if_valid_i   (if_valid_i),
        .if_instr_i   (if_instr_i),
        .if_pc_i      (if_pc_i),
        .wb_load_i    (wb_load_i),
        .wb_rd_i      (wb_rd_i),
        .wb_data_i    (wb_data_i),
        .ex_valid_o   (ex_valid_o),
        .ex_payload_o (ex_payload_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > timeout_cycles) begin
            $display("timeout: the test did not finish within %0d cycles", timeout_cycles);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [xlen-1:0] read_reg(input logic [reg_addr_width-1:0] a);
        if (a == '0) return '0;
        if (wb_load_i && wb_rd_i == a) return wb_data_i; // write-through
        return regs_m[a];
    endfunction

    function automatic id_ex_t model_decode(input if_id_t item);
        logic [xlen-1:0] ins;
        logic [2:0]      f3;
        logic [xlen-1:0] opb;
        id_ex_t          e;
        ins = item.instr;
        f3  = ins[14:12];
        e   = '0; // zero matches every control default
        e.instr   = ins;
        e.pc      = item.pc;
        e.rd      = ins[11:7];
        e.rs1_out = read_reg(ins[19:15]);
        e.rs2_out = read_reg(ins[24:20]);
        e.i_imm   = {{20{ins[31]}}, ins[31:20]};
        e.s_imm   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        e.b_imm   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        e.u_imm   = {ins[31:12], 12'b0};
        e.j_imm   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        e.ctrl.opcode = rv32i_opcode'(ins[6:0]);
        e.ctrl.aluop  = alu_ops'(f3);
        e.ctrl.funct3 = f3;
        case (ins[6:0])
            op_lui: begin
                e.ctrl.load_regfile   = 1'b1;
                e.ctrl.regfilemux_sel = regfilemux_u_imm;
            end
            op_auipc: begin
                e.ctrl.load_regfile = 1'b1;
                e.ctrl.aluop        = alu_add;
                e.ctrl.alumux1_sel  = alumux1_pc;
                e.ctrl.alumux2_sel  = alumux2_u_imm;
            end
            op_jal, op_jalr: begin
                e.ctrl.load_regfile   = 1'b1;
                e.ctrl.regfilemux_sel = regfilemux_pc_plus4;
                e.ctrl.aluop          = alu_add;
                if (ins[6:0] == op_jal) begin
                    e.ctrl.alumux1_sel = alumux1_pc;
                    e.ctrl.alumux2_sel = alumux2_j_imm;
                end
            end
            op_br: begin
                e.ctrl.aluop       = alu_add;
                e.ctrl.alumux1_sel = alumux1_pc;
                e.ctrl.alumux2_sel = alumux2_b_imm;
                e.ctrl.cmpop       = branch_funct3_t'(f3);
            end
            op_load: begin
                e.ctrl.load_regfile   = 1'b1;
                e.ctrl.mem_read       = 1'b1;
                e.ctrl.aluop          = alu_add;
                e.ctrl.regfilemux_sel = regfilemux_load;
            end
            op_store: begin
                e.ctrl.mem_write   = 1'b1;
                e.ctrl.aluop       = alu_add;
                e.ctrl.alumux2_sel = alumux2_s_imm;
            end
            op_imm, op_reg: begin
                e.ctrl.load_regfile = 1'b1;
                if (ins[6:0] == op_reg) e.ctrl.alumux2_sel = alumux2_rs2;
                if (f3[2:1] == 2'b01) begin // slt, sltu
                    e.ctrl.regfilemux_sel = regfilemux_br_en;
                    e.ctrl.cmpop          = f3[0] ? bltu : blt;
                    if (ins[6:0] == op_imm) e.ctrl.cmpmux_sel = cmpmux_i_imm;
                end
                e.ctrl.alu_sub_sra = ins[30] &&
                    (f3 == 3'b101 || (ins[6:0] == op_reg && f3 == 3'b000));
            end
            default: e.ctrl.illegal = 1'b1;
        endcase
        opb = (e.ctrl.cmpmux_sel == cmpmux_i_imm) ? e.i_imm : e.rs2_out;
        case (e.ctrl.cmpop)
            beq:     e.br_en = e.rs1_out == opb;
            bne:     e.br_en = e.rs1_out != opb;
            blt:     e.br_en = $signed(e.rs1_out) < $signed(opb);
            bge:     e.br_en = $signed(e.rs1_out) >= $signed(opb);
            bltu:    e.br_en = e.rs1_out < opb;
            bgeu:    e.br_en = e.rs1_out >= opb;
            default: e.br_en = 1'b0;
        endcase
        return e;
    endfunction

    // one clock edge of the two-stage model, using the inputs seen before the edge
    task automatic model_edge();
        id_ex_t dec;
        dec = model_decode(ifid_m);
        if (rst_i) begin
            ifid_v_m = 1'b0;
            ifid_m   = '0;
            ex_v_m   = 1'b0;
            ex_m     = '0;
            for (int i = 0; i < 32; i++) regs_m[i] = '0;
        end else begin
            if (flush_i) begin
                ifid_v_m = 1'b0;
                ex_v_m   = 1'b0;
            end else if (!stall_i) begin
                ex_v_m   = ifid_v_m;
                ex_m     = dec;
                ifid_v_m = if_valid_i;
                ifid_m   = '{instr: if_instr_i, pc: if_pc_i};
            end
            if (wb_load_i && wb_rd_i != '0) regs_m[wb_rd_i] = wb_data_i;
        end
    endtask

    function automatic logic [xlen-1:0] random_instr();
        logic [xlen-1:0] ins;
        logic [6:0]      op;
        ins = $urandom;
        case ($urandom % 10)
            0:       op = op_lui;
            1:       op = op_auipc;
            2:       op = op_jal;
            3:       op = op_jalr;
            4:       op = op_br;
            5:       op = op_load;
            6:       op = op_store;
            7:       op = op_imm;
            8:       op = op_reg;
            default: begin
                do begin
                    op = {5'($urandom), 2'b11}; // keep a 32-bit encoding
                end while (op inside {op_lui, op_auipc, op_jal, op_jalr, op_br,
                                      op_load, op_store, op_imm, op_reg});
            end
        endcase
        ins[6:0] = op;
        if ($urandom % 2 == 0) ins[19:15] = 5'($urandom % 4); // more register hits
        if ($urandom % 2 == 0) ins[24:20] = 5'($urandom % 4);
        return ins;
    endfunction

    task automatic drive_inputs(input logic active);
        rst_i      = !active;
        stall_i    = active && ($urandom % 8 == 0);
        flush_i    = active && ($urandom % 32 == 0);
        if_valid_i = active && ($urandom % 4 != 0);
        if_instr_i = random_instr();
        if_pc_i    = $urandom & 32'hffff_fffc;
        wb_load_i  = active && ($urandom % 2 == 0);
        wb_rd_i    = ($urandom % 2 == 0) ? 5'($urandom % 4) : 5'($urandom);
        wb_data_i  = ($urandom % 4 == 0) ? 32'($urandom % 8) : $urandom;
    endtask

    task automatic check_valid(input logic exp, input logic act);
        if (act !== exp) begin
            $display("error ex_valid_o expected %h got %h", exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "ex_valid_o mismatch");
        end
    endtask

    task automatic check_payload(input id_ex_t exp, input id_ex_t act);
        if (act !== exp) begin
            $display("error ex_payload_o expected %h got %h", exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "ex_payload_o mismatch");
        end
    endtask

    initial begin
        void'($urandom(46));
        drive_inputs(1'b0);
        for (int n = 0; n < reset_cycles + num_cycles; n++) begin
            @(posedge clk);
            #10;
            model_edge();
            check_valid(ex_v_m, ex_valid_o);
            if (ex_v_m) check_payload(ex_m, ex_payload_o);
            drive_inputs(n >= reset_cycles - 1); // release reset after 8 edges
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule : tb_decode_slice

//--- decode_slice.f
rv32i_types.sv
control_rom.sv
regfile.sv
pipe_reg.sv
id_stage.sv
decode_slice.sv
tb_decode_slice.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_decode_slice \
    -f decode_slice.f -o sim_decode_slice

out=$(./obj_dir/sim_decode_slice 2>&1 || true)
echo "$out"

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
